/* rx_lane_pkg.sv */
// Shared lane count, block constants, vector types and state enums for the rx lane pipeline
package rx_lane_pkg;

    // Lane count of the PHY interface
    localparam int NUM_LANES = 4;

    // Vector types
    typedef logic [63:0]          block_data_t;
    typedef logic [1:0]           sync_header_t;
    typedef logic [7:0]           block_type_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [7:0]           err_count_t;

    //////////////////////////////////////////////////
    // 64b/66b block encodings
    //////////////////////////////////////////////////
    localparam sync_header_t SYNC_DATA = 2'b01;
    localparam sync_header_t SYNC_CTRL = 2'b10;

    // Type byte sits in bits 7:0 of a control block
    localparam block_type_t BT_START = 8'h78;
    localparam block_type_t BT_TERM  = 8'h87;
    localparam block_type_t BT_IDLE  = 8'h1E;

    //////////////////////////////////////////////////
    // Classes and states
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        BLK_DATA,
        BLK_START,
        BLK_TERM,
        BLK_IDLE,
        BLK_ERROR
    } block_kind_e;

    typedef enum logic {
        ST_IDLE,
        ST_IN_FRAME
    } frame_state_e;

endpackage

/* lane_beat_if.sv */
// Carries one aligned four-lane beat from the deskew stage to the frame assembler
`timescale 1ns/1ns

interface lane_beat_if;

    // Beat is present only in the cycle where valid is high
    logic                                                valid;
    rx_lane_pkg::sync_header_t [rx_lane_pkg::NUM_LANES-1:0] header;
    rx_lane_pkg::block_data_t  [rx_lane_pkg::NUM_LANES-1:0] data;

    modport source (
        output valid,
        output header,
        output data
    );

    modport sink (
        input valid,
        input header,
        input data
    );

endinterface

/* frame_beat_if.sv */
// Carries one framed beat with keep and frame markers from the assembler to the output buffer
`timescale 1ns/1ns

interface frame_beat_if;

    logic                                                   valid;
    rx_lane_pkg::block_data_t [rx_lane_pkg::NUM_LANES-1:0]  data;
    rx_lane_pkg::lane_mask_t                                keep;
    // Frame markers and beat error
    logic                                                   sop;
    logic                                                   eop;
    logic                                                   err;

    modport source (
        output valid,
        output data,
        output keep,
        output sop,
        output eop,
        output err
    );

    modport sink (
        input valid,
        input data,
        input keep,
        input sop,
        input eop,
        input err
    );

endinterface

/* lane_block_decoder.sv */
// Classifies one 66-bit block as data, start, terminate, idle or error from header and type byte
`timescale 1ns/1ns

module lane_block_decoder (
    input  rx_lane_pkg::sync_header_t header_i,
    input  rx_lane_pkg::block_data_t  data_i,
    output rx_lane_pkg::block_kind_e  kind_o
);

    rx_lane_pkg::block_type_t type_byte;

    // Only meaningful for control blocks
    assign type_byte = data_i[7:0];

    always_comb begin
        kind_o = rx_lane_pkg::BLK_ERROR;
        case (header_i)
            rx_lane_pkg::SYNC_DATA: begin
                kind_o = rx_lane_pkg::BLK_DATA;
            end
            rx_lane_pkg::SYNC_CTRL: begin
                case (type_byte)
                    rx_lane_pkg::BT_START: begin
                        kind_o = rx_lane_pkg::BLK_START;
                    end
                    rx_lane_pkg::BT_TERM: begin
                        kind_o = rx_lane_pkg::BLK_TERM;
                    end
                    rx_lane_pkg::BT_IDLE: begin
                        kind_o = rx_lane_pkg::BLK_IDLE;
                    end
                    default: begin
                        kind_o = rx_lane_pkg::BLK_ERROR;
                    end
                endcase
            end
            // 2'b00 and 2'b11 are invalid sync headers
            default: begin
                kind_o = rx_lane_pkg::BLK_ERROR;
            end
        endcase
    end

endmodule

/* lane_deskew.sv */
// Per-lane deskew FIFOs; releases a registered four-lane beat once every lane holds a block
`timescale 1ns/1ns

module lane_deskew #(
    parameter int DESKEW_DEPTH = 8
) (
    input  logic                                                  clk_156,
    input  logic                                                  async_reset_n,
    input  rx_lane_pkg::lane_mask_t                               lane_valid_i,
    input  rx_lane_pkg::sync_header_t [rx_lane_pkg::NUM_LANES-1:0] lane_header_i,
    input  rx_lane_pkg::block_data_t  [rx_lane_pkg::NUM_LANES-1:0] lane_data_i,
    lane_beat_if.source                                           beat,
    output logic                                                  spill_o
);

    localparam int PTR_W = $clog2(DESKEW_DEPTH);
    localparam int CNT_W = $clog2(DESKEW_DEPTH + 1);

    rx_lane_pkg::lane_mask_t                               lane_ready;
    rx_lane_pkg::lane_mask_t                               lane_drop;
    rx_lane_pkg::sync_header_t [rx_lane_pkg::NUM_LANES-1:0] head_hdr;
    rx_lane_pkg::block_data_t  [rx_lane_pkg::NUM_LANES-1:0] head_data;
    logic                                                  pop_all;

    // All lanes advance together
    assign pop_all = &lane_ready;

    for (genvar i = 0; i < rx_lane_pkg::NUM_LANES; i++) begin : g_lane
        rx_lane_pkg::sync_header_t hdr_mem  [DESKEW_DEPTH];
        rx_lane_pkg::block_data_t  data_mem [DESKEW_DEPTH];
        logic [PTR_W-1:0]          wr_ptr;
        logic [PTR_W-1:0]          rd_ptr;
        logic [CNT_W-1:0]          count;
        logic                      push;

        assign lane_ready[i] = (count != '0);
        assign lane_drop[i]  = lane_valid_i[i] && (count == CNT_W'(DESKEW_DEPTH));
        assign push          = lane_valid_i[i] && !lane_drop[i];
        assign head_hdr[i]   = hdr_mem[rd_ptr];
        assign head_data[i]  = data_mem[rd_ptr];

        always_ff @(posedge clk_156) begin
            if (push) begin
                hdr_mem[wr_ptr]  <= lane_header_i[i];
                data_mem[wr_ptr] <= lane_data_i[i];
            end
        end

        always_ff @(posedge clk_156 or negedge async_reset_n) begin
            if (!async_reset_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == PTR_W'(DESKEW_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop_all) begin
                    rd_ptr <= (rd_ptr == PTR_W'(DESKEW_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                count <= count + CNT_W'(push) - CNT_W'(pop_all);
            end
        end
    end

    //////////////////////////////////////////////////
    // Beat register and spill flag
    //////////////////////////////////////////////////
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            beat.valid <= 1'b0;
            spill_o    <= 1'b0;
        end else begin
            beat.valid <= pop_all;
            // Sticky until reset
            if (|lane_drop) begin
                spill_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_156) begin
        beat.header <= head_hdr;
        beat.data   <= head_data;
    end

endmodule

/* frame_assembler.sv */
// Chains start and terminate across lanes and beats, builds keep/sop/eop/err and counts bad blocks
`timescale 1ns/1ns

module frame_assembler (
    input  logic                     clk_156,
    input  logic                     async_reset_n,
    lane_beat_if.sink                beat,
    frame_beat_if.source             frame,
    input  logic                     clear_errblk_i,
    output rx_lane_pkg::err_count_t  errd_blks_o
);

    localparam int NUM_W = $clog2(rx_lane_pkg::NUM_LANES + 1);

    rx_lane_pkg::block_kind_e   lane_kind [rx_lane_pkg::NUM_LANES];
    rx_lane_pkg::frame_state_e  state;
    rx_lane_pkg::frame_state_e  walk_state;
    rx_lane_pkg::lane_mask_t    keep_c;
    rx_lane_pkg::lane_mask_t    err_lanes;
    logic                       sop_c;
    logic                       eop_c;
    logic                       term_seen;
    logic [NUM_W-1:0]           err_num;
    logic [8:0]                 err_sum;

    for (genvar i = 0; i < rx_lane_pkg::NUM_LANES; i++) begin : g_dec
        lane_block_decoder u_dec (
            .header_i (beat.header[i]),
            .data_i   (beat.data[i]),
            .kind_o   (lane_kind[i])
        );
    end

    //////////////////////////////////////////////////
    // Lane walk, 0 to 3
    //////////////////////////////////////////////////
    always_comb begin
        walk_state = state;
        term_seen  = 1'b0;
        keep_c     = '0;
        err_lanes  = '0;
        sop_c      = 1'b0;
        eop_c      = 1'b0;
        for (int i = 0; i < rx_lane_pkg::NUM_LANES; i++) begin
            if (term_seen) begin
                // Only idles may follow a terminate
                err_lanes[i] = (lane_kind[i] != rx_lane_pkg::BLK_IDLE);
            end else if (walk_state == rx_lane_pkg::ST_IDLE) begin
                case (lane_kind[i])
                    rx_lane_pkg::BLK_START: begin
                        keep_c[i]  = 1'b1;
                        sop_c      = 1'b1;
                        walk_state = rx_lane_pkg::ST_IN_FRAME;
                    end
                    rx_lane_pkg::BLK_IDLE: ;
                    default: err_lanes[i] = 1'b1;
                endcase
            end else begin
                case (lane_kind[i])
                    rx_lane_pkg::BLK_DATA: keep_c[i] = 1'b1;
                    rx_lane_pkg::BLK_TERM: begin
                        eop_c      = 1'b1;
                        term_seen  = 1'b1;
                        walk_state = rx_lane_pkg::ST_IDLE;
                    end
                    default: err_lanes[i] = 1'b1;
                endcase
            end
        end
    end

    always_comb begin
        err_num = '0;
        for (int i = 0; i < rx_lane_pkg::NUM_LANES; i++) begin
            err_num = err_num + NUM_W'(err_lanes[i]);
        end
        err_sum = {1'b0, errd_blks_o} + 9'(err_num);
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            state       <= rx_lane_pkg::ST_IDLE;
            frame.valid <= 1'b0;
            errd_blks_o <= '0;
        end else begin
            frame.valid <= beat.valid && ((keep_c != '0) || (err_lanes != '0) || sop_c || eop_c);
            if (beat.valid) begin
                state <= walk_state;
            end
            if (clear_errblk_i) begin
                errd_blks_o <= '0;
            end else if (beat.valid) begin
                // Saturate at 255
                errd_blks_o <= err_sum[8] ? 8'hFF : err_sum[7:0];
            end
        end
    end

    always_ff @(posedge clk_156) begin
        frame.data <= beat.data;
        frame.keep <= keep_c;
        frame.sop  <= sop_c;
        frame.eop  <= eop_c;
        frame.err  <= (err_lanes != '0);
    end

endmodule

/* credit_tx_buffer.sv */
// Output FIFO of framed beats; a credit counter paces the beats issued to the consumer
`timescale 1ns/1ns

module credit_tx_buffer #(
    parameter int OUT_DEPTH    = 8,
    parameter int INIT_CREDITS = 4
) (
    input  logic                                                 clk_156,
    input  logic                                                 async_reset_n,
    frame_beat_if.sink                                           frame,
    input  logic                                                 credit_return_i,
    output logic                                                 frame_valid_o,
    output rx_lane_pkg::block_data_t [rx_lane_pkg::NUM_LANES-1:0] frame_data_o,
    output rx_lane_pkg::lane_mask_t                              frame_keep_o,
    output logic                                                 frame_sop_o,
    output logic                                                 frame_eop_o,
    output logic                                                 frame_err_o,
    output logic                                                 spill_o
);

    localparam int ENTRY_W = rx_lane_pkg::NUM_LANES * 64 + rx_lane_pkg::NUM_LANES + 3;
    localparam int PTR_W   = $clog2(OUT_DEPTH);
    localparam int CNT_W   = $clog2(OUT_DEPTH + 1);
    localparam int CRED_W  = $clog2(INIT_CREDITS + 1);

    logic [ENTRY_W-1:0] mem [OUT_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CRED_W-1:0]  credits;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    assign full  = (count == CNT_W'(OUT_DEPTH));
    assign empty = (count == '0);
    assign push  = frame.valid && !full;
    // One beat per credit
    assign pop   = !empty && (credits != '0);

    always_ff @(posedge clk_156) begin
        if (push) begin
            mem[wr_ptr] <= {frame.data, frame.keep, frame.sop, frame.eop, frame.err};
        end
        {frame_data_o, frame_keep_o, frame_sop_o, frame_eop_o, frame_err_o} <= mem[rd_ptr];
    end

    //////////////////////////////////////////////////
    // Pointers, credits and spill
    //////////////////////////////////////////////////
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credits       <= CRED_W'(INIT_CREDITS);
            frame_valid_o <= 1'b0;
            spill_o       <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count         <= count + CNT_W'(push) - CNT_W'(pop);
            credits       <= credits + CRED_W'(credit_return_i) - CRED_W'(pop);
            frame_valid_o <= pop;
            // Beat lost on a full FIFO
            if (frame.valid && full) begin
                spill_o <= 1'b1;
            end
        end
    end

endmodule

/* rx_lane_top.sv */
// Top level of the four-lane receive path: deskew, framing and credit-paced output
`timescale 1ns/1ns

module rx_lane_top #(
    parameter int DESKEW_DEPTH = 8,
    parameter int OUT_DEPTH    = 8,
    parameter int INIT_CREDITS = 4
) (
    input  logic                                                  clk_156,
    input  logic                                                  async_reset_n,
    input  rx_lane_pkg::lane_mask_t                               lane_valid_i,
    input  rx_lane_pkg::sync_header_t [rx_lane_pkg::NUM_LANES-1:0] lane_header_i,
    input  rx_lane_pkg::block_data_t  [rx_lane_pkg::NUM_LANES-1:0] lane_data_i,
    input  logic                                                  clear_errblk_i,
    input  logic                                                  credit_return_i,
    output logic                                                  frame_valid_o,
    output rx_lane_pkg::block_data_t  [rx_lane_pkg::NUM_LANES-1:0] frame_data_o,
    output rx_lane_pkg::lane_mask_t                               frame_keep_o,
    output logic                                                  frame_sop_o,
    output logic                                                  frame_eop_o,
    output logic                                                  frame_err_o,
    output rx_lane_pkg::err_count_t                               errd_blks_o,
    output logic                                                  fifo_spill_o
);

    logic deskew_spill;
    logic out_spill;

    lane_beat_if  u_lane_beat ();
    frame_beat_if u_frame_beat ();

    lane_deskew #(
        .DESKEW_DEPTH (DESKEW_DEPTH)
    ) u_lane_deskew (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .lane_valid_i  (lane_valid_i),
        .lane_header_i (lane_header_i),
        .lane_data_i   (lane_data_i),
        .beat          (u_lane_beat.source),
        .spill_o       (deskew_spill)
    );

    frame_assembler u_frame_assembler (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .beat           (u_lane_beat.sink),
        .frame          (u_frame_beat.source),
        .clear_errblk_i (clear_errblk_i),
        .errd_blks_o    (errd_blks_o)
    );

    credit_tx_buffer #(
        .OUT_DEPTH    (OUT_DEPTH),
        .INIT_CREDITS (INIT_CREDITS)
    ) u_credit_tx_buffer (
        .clk_156         (clk_156),
        .async_reset_n   (async_reset_n),
        .frame           (u_frame_beat.sink),
        .credit_return_i (credit_return_i),
        .frame_valid_o   (frame_valid_o),
        .frame_data_o    (frame_data_o),
        .frame_keep_o    (frame_keep_o),
        .frame_sop_o     (frame_sop_o),
        .frame_eop_o     (frame_eop_o),
        .frame_err_o     (frame_err_o),
        .spill_o         (out_spill)
    );

    // Either buffer losing a beat
    assign fifo_spill_o = deskew_spill | out_spill;

endmodule

/* tb_rx_lane_sva.sv */
// Concurrent checks on the rx_lane_top ports, bound into the DUT from this file
`timescale 1ns/1ns

module tb_rx_lane_sva #(
    parameter int INIT_CREDITS = 4
) (
    input logic                    clk_156,
    input logic                    async_reset_n,
    input rx_lane_pkg::lane_mask_t lane_valid_i,
    input logic                    credit_return_i,
    input logic                    frame_valid_o,
    input logic                    fifo_spill_o,
    input rx_lane_pkg::err_count_t errd_blks_o
);

    logic seen_input;
    int   beats_out;
    int   credits_in;

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            seen_input <= 1'b0;
            beats_out  <= 0;
            credits_in <= 0;
        end else begin
            if (lane_valid_i != '0) begin
                seen_input <= 1'b1;
            end
            beats_out  <= beats_out + int'(frame_valid_o);
            credits_in <= credits_in + int'(credit_return_i);
        end
    end

    // Quiet outputs before any lane block arrives
    a_quiet_after_reset: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        !seen_input |-> (!frame_valid_o && !fifo_spill_o && errd_blks_o == '0))
        else $error("output activity before any lane input");

    a_credit_bound: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        beats_out <= credits_in + INIT_CREDITS)
        else $error("more output beats than credits granted");

    a_spill_sticky: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        fifo_spill_o |=> fifo_spill_o)
        else $error("spill flag dropped without reset");

endmodule

bind rx_lane_top tb_rx_lane_sva #(.INIT_CREDITS(INIT_CREDITS)) u_sva (
    .clk_156         (clk_156),
    .async_reset_n   (async_reset_n),
    .lane_valid_i    (lane_valid_i),
    .credit_return_i (credit_return_i),
    .frame_valid_o   (frame_valid_o),
    .fifo_spill_o    (fifo_spill_o),
    .errd_blks_o     (errd_blks_o)
);

/* tb_rx_lane_top.sv */
// Testbench for rx_lane_top; drives framed lane traffic and checks every output beat against a model
`timescale 1ns/1ns

module tb_rx_lane_top;

    localparam int DESKEW_DEPTH = 8;
    localparam int OUT_DEPTH    = 8;
    localparam int INIT_CREDITS = 4;
    localparam int NL           = rx_lane_pkg::NUM_LANES;
    localparam int EXP_W        = NL * 64 + NL + 3;
    // About 200 beats of traffic plus drain and hold waits, with margin
    localparam int MAX_CYCLES   = 3000;

    logic                                          clk_156         = 1'b0;
    logic                                          async_reset_n   = 1'b0;
    rx_lane_pkg::lane_mask_t                       lane_valid_i    = '0;
    rx_lane_pkg::sync_header_t [NL-1:0]            lane_header_i   = '0;
    rx_lane_pkg::block_data_t  [NL-1:0]            lane_data_i     = '0;
    logic                                          clear_errblk_i  = 1'b0;
    logic                                          credit_return_i = 1'b0;
    logic                                          frame_valid_o;
    rx_lane_pkg::block_data_t  [NL-1:0]            frame_data_o;
    rx_lane_pkg::lane_mask_t                       frame_keep_o;
    logic                                          frame_sop_o;
    logic                                          frame_eop_o;
    logic                                          frame_err_o;
    rx_lane_pkg::err_count_t                       errd_blks_o;
    logic                                          fifo_spill_o;

    logic [NL*66-1:0]          pend_q [$];
    logic [EXP_W-1:0]          exp_q [$];
    rx_lane_pkg::block_kind_e  kind_sel [NL];
    int                        fill_pos      = 0;
    bit                        ref_in_frame  = 1'b0;
    int                        ref_errs      = 0;
    logic                      hold_credits  = 1'b0;
    int                        owed          = 0;
    int                        owed_next     = 0;
    int                        cycles        = 0;
    int                        beats_checked = 0;
    int                        value_errs    = 0;
    int                        other_errs    = 0;

    rx_lane_top #(
        .DESKEW_DEPTH (DESKEW_DEPTH),
        .OUT_DEPTH    (OUT_DEPTH),
        .INIT_CREDITS (INIT_CREDITS)
    ) u_rx_lane_top (.*);

    always #2 clk_156 = ~clk_156;

    //////////////////////////////////////////////////
    // Stimulus builders and reference model
    //////////////////////////////////////////////////
    function automatic logic [65:0] make_block(input rx_lane_pkg::block_kind_e kind);
        logic [63:0] r;
        logic [1:0]  bad_hdr;
        r       = {$urandom, $urandom};
        bad_hdr = ($urandom_range(0, 1) == 0) ? 2'b00 : 2'b11;
        case (kind)
            rx_lane_pkg::BLK_DATA:  make_block = {rx_lane_pkg::SYNC_DATA, r};
            rx_lane_pkg::BLK_START: make_block = {rx_lane_pkg::SYNC_CTRL, r[63:8],
                                                  rx_lane_pkg::BT_START};
            rx_lane_pkg::BLK_TERM:  make_block = {rx_lane_pkg::SYNC_CTRL, r[63:8],
                                                  rx_lane_pkg::BT_TERM};
            rx_lane_pkg::BLK_IDLE:  make_block = {rx_lane_pkg::SYNC_CTRL, r[63:8],
                                                  rx_lane_pkg::BT_IDLE};
            default:                make_block = {bad_hdr, r};
        endcase
    endfunction

    // One beat through the framing rules, lanes 0 to 3
    task automatic add_beat();
        logic [NL*66-1:0]        blocks;
        logic [NL*64-1:0]        data;
        logic [65:0]             blk;
        rx_lane_pkg::lane_mask_t keep;
        logic                    sop;
        logic                    eop;
        logic                    done;
        logic                    bad;
        int                      nerr;
        keep = '0;
        sop  = 1'b0;
        eop  = 1'b0;
        done = 1'b0;
        nerr = 0;
        for (int i = 0; i < NL; i++) begin
            blk = make_block(kind_sel[i]);
            blocks[i*66 +: 66] = blk;
            data[i*64 +: 64]   = blk[63:0];
            bad = 1'b0;
            if (done) begin
                bad = (kind_sel[i] != rx_lane_pkg::BLK_IDLE);
            end else if (!ref_in_frame) begin
                if (kind_sel[i] == rx_lane_pkg::BLK_START) begin
                    keep[i]      = 1'b1;
                    sop          = 1'b1;
                    ref_in_frame = 1'b1;
                end else if (kind_sel[i] != rx_lane_pkg::BLK_IDLE) begin
                    bad = 1'b1;
                end
            end else if (kind_sel[i] == rx_lane_pkg::BLK_DATA) begin
                keep[i] = 1'b1;
            end else if (kind_sel[i] == rx_lane_pkg::BLK_TERM) begin
                eop          = 1'b1;
                done         = 1'b1;
                ref_in_frame = 1'b0;
            end else begin
                bad = 1'b1;
            end
            if (bad) begin
                nerr++;
            end
        end
        pend_q.push_back(blocks);
        ref_errs = (ref_errs + nerr > 255) ? 255 : ref_errs + nerr;
        if (keep != '0 || nerr != 0 || sop || eop) begin
            exp_q.push_back({data, keep, sop, eop, (nerr != 0)});
        end
    endtask

    task automatic put_block(input rx_lane_pkg::block_kind_e kind);
        kind_sel[fill_pos] = kind;
        fill_pos++;
        if (fill_pos == NL) begin
            add_beat();
            fill_pos = 0;
        end
    endtask

    task automatic pad_beat();
        while (fill_pos != 0) begin
            put_block(rx_lane_pkg::BLK_IDLE);
        end
    endtask

    // Start lane set by the leading idles
    task automatic add_frame(input int n_data);
        int lead;
        lead = $urandom_range(0, 3);
        repeat (lead) put_block(rx_lane_pkg::BLK_IDLE);
        put_block(rx_lane_pkg::BLK_START);
        repeat (n_data) put_block(rx_lane_pkg::BLK_DATA);
        put_block(rx_lane_pkg::BLK_TERM);
        pad_beat();
    endtask

    // Each lane starts after its own random lag, then streams one block per cycle
    task automatic run_feed(input int max_lag);
        int               lag [NL];
        int               ptr [NL];
        logic [NL*66-1:0] blocks;
        bit               busy;
        for (int i = 0; i < NL; i++) begin
            lag[i] = $urandom_range(0, max_lag);
            ptr[i] = 0;
        end
        busy = 1'b1;
        while (busy) begin
            @(posedge clk_156);
            busy = 1'b0;
            for (int i = 0; i < NL; i++) begin
                if (lag[i] > 0) begin
                    lag[i]--;
                    lane_valid_i[i] <= 1'b0;
                    busy = 1'b1;
                end else if (ptr[i] < pend_q.size()) begin
                    blocks = pend_q[ptr[i]];
                    lane_valid_i[i]  <= 1'b1;
                    lane_header_i[i] <= blocks[i*66+64 +: 2];
                    lane_data_i[i]   <= blocks[i*66 +: 64];
                    ptr[i]++;
                    busy = 1'b1;
                end else begin
                    lane_valid_i[i] <= 1'b0;
                end
            end
        end
        pend_q.delete();
    endtask

    task automatic wait_quiet();
        @(posedge clk_156);
        while (exp_q.size() != 0 || owed != 0) begin
            @(posedge clk_156);
        end
        repeat (4) @(posedge clk_156);
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic check_err_count();
        assert (errd_blks_o == 8'(ref_errs)) else begin
            value_errs++;
            $display("ERR %0t: errd_blks_o is %0d, expected %0d", $time, errd_blks_o, ref_errs);
        end
    endtask

    task automatic check_beat();
        logic [EXP_W-1:0] got;
        logic [EXP_W-1:0] exp;
        got = {frame_data_o, frame_keep_o, frame_sop_o, frame_eop_o, frame_err_o};
        if (exp_q.size() == 0) begin
            other_errs++;
            $display("An output beat arrived at %0t when none was expected", $time);
        end else begin
            exp = exp_q.pop_front();
            beats_checked++;
            assert (got == exp) else begin
                value_errs++;
                $display("ERR %0t: beat %0d keep/sop/eop/err %b expected %b, data ok %0b",
                         $time, beats_checked, got[6:0], exp[6:0],
                         got[EXP_W-1:7] == exp[EXP_W-1:7]);
            end
        end
    endtask

    // Consumer side: one credit back per received beat unless held
    always @(posedge clk_156) begin
        if (!async_reset_n) begin
            owed            <= 0;
            credit_return_i <= 1'b0;
        end else begin
            owed_next = owed + int'(frame_valid_o) - int'(credit_return_i);
            owed            <= owed_next;
            credit_return_i <= !hold_credits && (owed_next > 0);
            if (frame_valid_o) begin
                check_beat();
            end
        end
    end

    always @(posedge clk_156) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        rx_lane_pkg::block_kind_e seq [20];
        void'($urandom(32'h34c4dc5a));
        repeat (2) @(posedge clk_156);
        async_reset_n <= 1'b1;
        repeat (5) @(posedge clk_156);
        check_err_count();

        // Aligned lanes, prompt credits
        repeat (12) add_frame($urandom_range(0, 10));
        run_feed(0);
        wait_quiet();
        check_err_count();

        // Skewed lanes
        repeat (12) add_frame($urandom_range(0, 10));
        run_feed(3);
        wait_quiet();
        check_err_count();

        // Credits held back, output must stall
        hold_credits <= 1'b1;
        repeat (2) add_frame(8);
        run_feed(0);
        repeat (20) @(posedge clk_156);
        assert (exp_q.size() > 0) else begin
            other_errs++;
            $display("Output kept flowing while credits were withheld");
        end
        hold_credits <= 1'b0;
        wait_quiet();

        // Bad header, data outside a frame, start inside a frame, data after terminate
        seq = '{rx_lane_pkg::BLK_START, rx_lane_pkg::BLK_DATA, rx_lane_pkg::BLK_ERROR,
                rx_lane_pkg::BLK_DATA, rx_lane_pkg::BLK_TERM, rx_lane_pkg::BLK_IDLE,
                rx_lane_pkg::BLK_IDLE, rx_lane_pkg::BLK_IDLE, rx_lane_pkg::BLK_DATA,
                rx_lane_pkg::BLK_IDLE, rx_lane_pkg::BLK_DATA, rx_lane_pkg::BLK_IDLE,
                rx_lane_pkg::BLK_START, rx_lane_pkg::BLK_DATA, rx_lane_pkg::BLK_START,
                rx_lane_pkg::BLK_DATA, rx_lane_pkg::BLK_TERM, rx_lane_pkg::BLK_DATA,
                rx_lane_pkg::BLK_IDLE, rx_lane_pkg::BLK_IDLE};
        for (int i = 0; i < 20; i++) begin
            put_block(seq[i]);
        end
        run_feed(0);
        wait_quiet();
        check_err_count();
        clear_errblk_i <= 1'b1;
        @(posedge clk_156);
        clear_errblk_i <= 1'b0;
        ref_errs = 0;
        repeat (2) @(posedge clk_156);
        check_err_count();

        // Overflow of the output FIFO with no credits coming back
        assert (!fifo_spill_o) else begin
            other_errs++;
            $display("The spill flag was set before the overflow test");
        end
        hold_credits <= 1'b1;
        put_block(rx_lane_pkg::BLK_START);
        repeat (4 * (INIT_CREDITS + OUT_DEPTH + 1) - 1) put_block(rx_lane_pkg::BLK_DATA);
        put_block(rx_lane_pkg::BLK_TERM);
        pad_beat();
        run_feed(0);
        repeat (20) @(posedge clk_156);
        assert (fifo_spill_o) else begin
            other_errs++;
            $display("The spill flag did not set after the output FIFO overflowed");
        end
        assert (exp_q.size() == OUT_DEPTH + 2) else begin
            other_errs++;
            $display("Wrong number of beats left behind after overflow: %0d", exp_q.size());
        end

        $display("Summary: %0d beats checked, %0d value errors, %0d other errors",
                 beats_checked, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
rx_lane_pkg.sv
lane_beat_if.sv
frame_beat_if.sv
lane_block_decoder.sv
lane_deskew.sv
frame_assembler.sv
credit_tx_buffer.sv
rx_lane_top.sv
tb_rx_lane_sva.sv
tb_rx_lane_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rx lane testbench with Verilator, then judge the result from sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_rx_lane_top \
    -o sim_rx_lane > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_rx_lane > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }
